/* ntm_defs.svh */
// Fixed-point format constants for the NTM controller neuron
// Word and fraction widths, saturation limits, logistic segment constants
`ifndef NTM_DEFS_SVH
`define NTM_DEFS_SVH

// Q4.12 signed word
`define NTM_DATA_W 16
`define NTM_FRAC_W 12

// Saturation limits of the signed word
`define NTM_MAX 16'sh7FFF
`define NTM_MIN 16'sh8000
`define NTM_ONE 16'sh1000

// Logistic breakpoints 1.0, 2.375, 5.0
`define NTM_SIG_BRK1 16'sh1000
`define NTM_SIG_BRK2 16'sh2600
`define NTM_SIG_BRK3 16'sh5000
// Segment offsets 0.5, 0.625, 0.84375
`define NTM_SIG_OFF1 16'sh0800
`define NTM_SIG_OFF2 16'sh0A00
`define NTM_SIG_OFF3 16'sh0D80

`endif

/* ntm_pkg.sv */
// Shared types of the NTM controller neuron
// Fixed-point word union and sequencer step encoding
`default_nettype none

`include "ntm_defs.svh"

package ntm_pkg;

  //////////////////////////////////////////////////////////////////////
  // Fixed-point word
  //////////////////////////////////////////////////////////////////////

  // Same 16 bits, two readings
  // s for arithmetic, q for segment decode in the logistic unit
  typedef union packed {
    logic signed [`NTM_DATA_W-1:0] s;
    struct packed {
      logic [`NTM_DATA_W-`NTM_FRAC_W-1:0] int_part;
      logic [`NTM_FRAC_W-1:0]             frac;
    } q;
  } fixed_t;

  //////////////////////////////////////////////////////////////////////
  // Sequencer steps
  //////////////////////////////////////////////////////////////////////

  // One step per clock, IDLE waits for START
  typedef enum logic [2:0] {
    IDLE,
    MAC_WX,
    MAC_KR,
    MAC_UH,
    LOGISTIC,
    DONE
  } step_t;

endpackage

`default_nettype wire

/* ntm_fixed_mac.sv */
// Saturating Q4.12 multiply-accumulate
// Load starts a new sum from the bias, add extends the running sum
`timescale 1ns/1ps
`default_nettype none

`include "ntm_defs.svh"

module ntm_fixed_mac (
  input  logic            CLK,
  input  logic            RST,
  input  logic            load,
  input  logic            add,
  input  ntm_pkg::fixed_t a,
  input  ntm_pkg::fixed_t b,
  input  ntm_pkg::fixed_t bias,
  output ntm_pkg::fixed_t acc
);

  // Word, shifted product and widened sum widths
  localparam int W  = `NTM_DATA_W;
  localparam int PW = 2 * W - `NTM_FRAC_W;
  localparam int SW = PW + 1;

  logic signed [2*W-1:0] prod_full;
  logic signed [PW-1:0]  prod;
  logic signed [W-1:0]   addend;
  logic signed [SW-1:0]  sum;
  ntm_pkg::fixed_t       acc_next;

  //////////////////////////////////////////////////////////////////////
  // Product and sum
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Full product, then drop fraction bits
    prod_full = $signed(a.s) * $signed(b.s);
    // Upper slice is the arithmetic shift, rounds toward minus infinity
    prod      = prod_full[2*W-1:`NTM_FRAC_W];
    // Load wins over add
    addend    = load ? bias.s : acc.s;
    // Wide enough that nothing wraps before the clamp
    sum       = addend + prod;
    if (sum > `NTM_MAX) begin
      acc_next.s = `NTM_MAX;
    end else if (sum < `NTM_MIN) begin
      acc_next.s = `NTM_MIN;
    end else begin
      acc_next.s = sum[W-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Accumulator register
  //////////////////////////////////////////////////////////////////////

  // One cycle from strobe to updated acc
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc <= '0;
    end else if (load || add) begin
      acc <= acc_next;
    end
  end

endmodule

`default_nettype wire

/* ntm_logistic.sv */
// Registered piecewise-linear logistic function
// Four segments on the magnitude, mirrored around 0.5 for negative input
`timescale 1ns/1ps
`default_nettype none

`include "ntm_defs.svh"

module ntm_logistic (
  input  logic            CLK,
  input  logic            RST,
  input  logic            start,
  input  ntm_pkg::fixed_t x,
  output ntm_pkg::fixed_t y,
  output logic            valid
);

  // Breakpoints viewed through the union for field compares
  localparam ntm_pkg::fixed_t BRK1 = `NTM_SIG_BRK1;
  localparam ntm_pkg::fixed_t BRK2 = `NTM_SIG_BRK2;
  localparam ntm_pkg::fixed_t BRK3 = `NTM_SIG_BRK3;

  ntm_pkg::fixed_t mag;
  ntm_pkg::fixed_t seg;
  ntm_pkg::fixed_t y_next;
  logic            neg;

  // Magnitude at or above a breakpoint
  // Integer field decides, fraction field only on a tie
  function automatic logic at_or_above(input ntm_pkg::fixed_t m,
                                       input ntm_pkg::fixed_t brk);
    logic ge;
    if (m.q.int_part != brk.q.int_part) begin
      ge = (m.q.int_part > brk.q.int_part);
    end else begin
      ge = (m.q.frac >= brk.q.frac);
    end
    return ge;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Magnitude and segment select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    neg = x.s[`NTM_DATA_W-1];
    // Most negative word has no positive twin, clamp it
    if (x.s == `NTM_MIN) begin
      mag.s = `NTM_MAX;
    end else if (neg) begin
      mag.s = -x.s;
    end else begin
      mag.s = x.s;
    end

    // Magnitude is never negative here, logical shifts are safe
    if (at_or_above(mag, BRK3)) begin
      seg.s = `NTM_ONE;
    end else if (at_or_above(mag, BRK2)) begin
      seg.s = (mag.s >> 5) + `NTM_SIG_OFF3;
    end else if (at_or_above(mag, BRK1)) begin
      seg.s = (mag.s >> 3) + `NTM_SIG_OFF2;
    end else begin
      seg.s = (mag.s >> 2) + `NTM_SIG_OFF1;
    end

    // logistic(-m) = 1 - logistic(m)
    y_next.s = neg ? (`NTM_ONE - seg.s) : seg.s;
  end

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  // Valid is a single-cycle echo of start
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      valid <= 1'b0;
    end else begin
      valid <= start;
    end
  end

  // Result only moves on start
  always_ff @(posedge CLK) begin
    if (start) begin
      y <= y_next;
    end
  end

endmodule

`default_nettype wire

/* ntm_sequencer.sv */
// Step FSM of the controller neuron
// Operand steering into the MAC, logistic start, hidden state
// READY and H_OUT result outputs
`timescale 1ns/1ps
`default_nettype none

module ntm_sequencer (
  input  logic            CLK,
  input  logic            RST,
  input  logic            START,
  input  ntm_pkg::fixed_t w_in,
  input  ntm_pkg::fixed_t x_in,
  input  ntm_pkg::fixed_t k_in,
  input  ntm_pkg::fixed_t r_in,
  input  ntm_pkg::fixed_t u_in,
  input  ntm_pkg::fixed_t logistic_y,
  input  logic            logistic_valid,
  output logic            mac_load,
  output logic            mac_add,
  output logic            logistic_start,
  output ntm_pkg::fixed_t mac_a,
  output ntm_pkg::fixed_t mac_b,
  output logic            READY,
  output logic            H_OUT_ENABLE,
  output ntm_pkg::fixed_t H_OUT
);

  ntm_pkg::step_t  step;
  // Recurrent state, h(t-1)
  ntm_pkg::fixed_t h_state;

  //////////////////////////////////////////////////////////////////////
  // Operand steering
  //////////////////////////////////////////////////////////////////////

  // Decoded from the current step, MAC sees it on the next edge
  always_comb begin
    mac_load       = 1'b0;
    mac_add        = 1'b0;
    logistic_start = 1'b0;
    mac_a          = w_in;
    mac_b          = x_in;
    case (step)
      // b + W*x
      ntm_pkg::MAC_WX: begin
        mac_load = 1'b1;
      end
      // + K*r
      ntm_pkg::MAC_KR: begin
        mac_add = 1'b1;
        mac_a   = k_in;
        mac_b   = r_in;
      end
      // + U*h_prev
      ntm_pkg::MAC_UH: begin
        mac_add = 1'b1;
        mac_a   = u_in;
        mac_b   = h_state;
      end
      // acc now holds the full sum
      ntm_pkg::LOGISTIC: begin
        logistic_start = 1'b1;
      end
      default: begin
        mac_load = 1'b0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Step FSM and result registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      step         <= ntm_pkg::IDLE;
      READY        <= 1'b0;
      H_OUT_ENABLE <= 1'b0;
      H_OUT        <= '0;
      h_state      <= '0;
    end else begin
      // Result strobe is a pulse
      H_OUT_ENABLE <= 1'b0;
      case (step)
        ntm_pkg::IDLE: begin
          // START only counts here, ignored while busy
          if (START) begin
            step  <= ntm_pkg::MAC_WX;
            READY <= 1'b0;
          end
        end
        ntm_pkg::MAC_WX: begin
          step <= ntm_pkg::MAC_KR;
        end
        ntm_pkg::MAC_KR: begin
          step <= ntm_pkg::MAC_UH;
        end
        ntm_pkg::MAC_UH: begin
          step <= ntm_pkg::LOGISTIC;
        end
        ntm_pkg::LOGISTIC: begin
          step <= ntm_pkg::DONE;
        end
        ntm_pkg::DONE: begin
          // Logistic result lands here, one cycle after start
          if (logistic_valid) begin
            H_OUT        <= logistic_y;
            h_state      <= logistic_y;
            H_OUT_ENABLE <= 1'b1;
          end
          READY <= 1'b1;
          step  <= ntm_pkg::IDLE;
        end
        default: begin
          step <= ntm_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* ntm_neuron_top.sv */
// Top level of the NTM controller neuron
// h = logistic(W*x + K*r + U*h_prev + b) on Q4.12 scalars
`timescale 1ns/1ps
`default_nettype none

module ntm_neuron_top (
  input  logic            CLK,
  input  logic            RST,
  input  logic            START,
  input  ntm_pkg::fixed_t W_IN,
  input  ntm_pkg::fixed_t X_IN,
  input  ntm_pkg::fixed_t K_IN,
  input  ntm_pkg::fixed_t R_IN,
  input  ntm_pkg::fixed_t U_IN,
  input  ntm_pkg::fixed_t B_IN,
  output logic            READY,
  output ntm_pkg::fixed_t H_OUT,
  output logic            H_OUT_ENABLE
);

  // Sequencer to MAC
  logic            mac_load;
  logic            mac_add;
  ntm_pkg::fixed_t mac_a;
  ntm_pkg::fixed_t mac_b;
  // MAC to logistic
  ntm_pkg::fixed_t acc;
  // Logistic handshake
  logic            logistic_start;
  ntm_pkg::fixed_t logistic_y;
  logic            logistic_valid;

  //////////////////////////////////////////////////////////////////////
  // Step control
  //////////////////////////////////////////////////////////////////////

  ntm_sequencer u_sequencer (
    .CLK           (CLK),
    .RST           (RST),
    .START         (START),
    .w_in          (W_IN),
    .x_in          (X_IN),
    .k_in          (K_IN),
    .r_in          (R_IN),
    .u_in          (U_IN),
    .logistic_y    (logistic_y),
    .logistic_valid(logistic_valid),
    .mac_load      (mac_load),
    .mac_add       (mac_add),
    .logistic_start(logistic_start),
    .mac_a         (mac_a),
    .mac_b         (mac_b),
    .READY         (READY),
    .H_OUT_ENABLE  (H_OUT_ENABLE),
    .H_OUT         (H_OUT)
  );

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  // Bias enters only with the first product
  ntm_fixed_mac u_mac (
    .CLK (CLK),
    .RST (RST),
    .load(mac_load),
    .add (mac_add),
    .a   (mac_a),
    .b   (mac_b),
    .bias(B_IN),
    .acc (acc)
  );

  ntm_logistic u_logistic (
    .CLK  (CLK),
    .RST  (RST),
    .start(logistic_start),
    .x    (acc),
    .y    (logistic_y),
    .valid(logistic_valid)
  );

endmodule

`default_nettype wire

/* ntm_neuron_asserts.sv */
// Concurrent checks on the neuron top-level timing
// Result latency, single-cycle result strobe, READY against the step FSM
`timescale 1ns/1ps
`default_nettype none

module ntm_neuron_asserts (
  input logic           CLK,
  input logic           RST,
  input logic           START,
  input logic           READY,
  input logic           H_OUT_ENABLE,
  input ntm_pkg::step_t step
);

  // START only counts while the FSM sits in IDLE
  logic accepted;
  // Number of failed assertions
  int   fail_count = 0;

  assign accepted = START && (step == ntm_pkg::IDLE);

  //////////////////////////////////////////////////////////////////////
  // Handshake timing
  //////////////////////////////////////////////////////////////////////

  // Strobe exactly 6 edges after each accepted START, never otherwise
  enable_after_start: assert property (@(posedge CLK) disable iff (RST)
    H_OUT_ENABLE == $past(accepted, 6))
    else begin
      fail_count++;
      $error("H_OUT_ENABLE not 6 cycles after an accepted START");
    end

  // Result strobe is one cycle wide
  enable_single_cycle: assert property (@(posedge CLK) disable iff (RST)
    H_OUT_ENABLE |=> !H_OUT_ENABLE)
    else begin
      fail_count++;
      $error("H_OUT_ENABLE high for two cycles in a row");
    end

  // Busy means not ready
  ready_low_when_busy: assert property (@(posedge CLK) disable iff (RST)
    (step != ntm_pkg::IDLE) |-> !READY)
    else begin
      fail_count++;
      $error("READY high while the sequencer is busy");
    end

endmodule

`default_nettype wire

/* ntm_neuron_tb.sv */
// Testbench for the NTM controller neuron
// Directed and random stimulus table, reference model, compare tasks
// Watchdog, error counts and final verdict
`timescale 1ns/1ps
`default_nettype none

`include "ntm_defs.svh"

module ntm_neuron_tb;

  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 10;
  localparam int RESULT_LATENCY  = 6;
  localparam int LAT_LIMIT       = 12;
  localparam int N_DIRECTED      = 18;
  localparam int N_RANDOM        = 40;
  localparam int N_RESET_ROWS    = 3;
  // Ten cycles per row plus every reset, the initial one included
  localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * 10
                                   + (N_RESET_ROWS + 1) * (RESET_CYCLES + 2);

  // One stimulus row and its expected result
  typedef struct packed {
    logic [`NTM_DATA_W-1:0] w;
    logic [`NTM_DATA_W-1:0] x;
    logic [`NTM_DATA_W-1:0] k;
    logic [`NTM_DATA_W-1:0] r;
    logic [`NTM_DATA_W-1:0] u;
    logic [`NTM_DATA_W-1:0] b;
    logic                   rst_first;
    logic                   busy_start;
    logic [`NTM_DATA_W-1:0] exp_h;
  } row_t;

  logic            CLK;
  logic            RST;
  logic            start;
  ntm_pkg::fixed_t w_in;
  ntm_pkg::fixed_t x_in;
  ntm_pkg::fixed_t k_in;
  ntm_pkg::fixed_t r_in;
  ntm_pkg::fixed_t u_in;
  ntm_pkg::fixed_t b_in;
  logic            ready;
  logic            h_out_enable;
  ntm_pkg::fixed_t h_out;

  row_t   rows[$];
  integer seed;
  int     mismatches;
  int     failures;
  // READY level expected while idle, low until the first result
  logic   ready_exp;

  ntm_neuron_top dut0 (
    .CLK         (CLK),
    .RST         (RST),
    .START       (start),
    .W_IN        (w_in),
    .X_IN        (x_in),
    .K_IN        (k_in),
    .R_IN        (r_in),
    .U_IN        (u_in),
    .B_IN        (b_in),
    .READY       (ready),
    .H_OUT       (h_out),
    .H_OUT_ENABLE(h_out_enable)
  );

  bind ntm_neuron_top ntm_neuron_asserts u_asserts (
    .CLK         (CLK),
    .RST         (RST),
    .START       (START),
    .READY       (READY),
    .H_OUT_ENABLE(H_OUT_ENABLE),
    .step        (u_sequencer.step)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Q4.12 product, floor of the exact value
  function automatic int fixed_mul(input logic [15:0] a, input logic [15:0] b);
    int sa;
    int sb;
    sa = $signed(a);
    sb = $signed(b);
    return (sa * sb) >>> `NTM_FRAC_W;
  endfunction

  function automatic int saturate(input int v);
    int s;
    s = v;
    if (v > `NTM_MAX) s = `NTM_MAX;
    if (v < `NTM_MIN) s = `NTM_MIN;
    return s;
  endfunction

  // Segments on |v|, mirrored for negative input
  function automatic int logistic_approx(input int v);
    int m;
    int seg;
    m = (v < 0) ? -v : v;
    if (v == `NTM_MIN) m = `NTM_MAX;
    if (m >= `NTM_SIG_BRK3) seg = `NTM_ONE;
    else if (m >= `NTM_SIG_BRK2) seg = (m >>> 5) + `NTM_SIG_OFF3;
    else if (m >= `NTM_SIG_BRK1) seg = (m >>> 3) + `NTM_SIG_OFF2;
    else seg = (m >>> 2) + `NTM_SIG_OFF1;
    return (v < 0) ? (`NTM_ONE - seg) : seg;
  endfunction

  function automatic logic [15:0] expected_h(input row_t rw, input logic [15:0] h_prev);
    int acc;
    int y;
    acc = $signed(rw.b);
    acc = saturate(acc + fixed_mul(rw.w, rw.x));
    acc = saturate(acc + fixed_mul(rw.k, rw.r));
    acc = saturate(acc + fixed_mul(rw.u, h_prev));
    y = logistic_approx(acc);
    return y[15:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////////////////////////

  task automatic add_row(input logic [15:0] w, x, k, r, u, b, input logic rst_first,
                         input logic busy_start);
    row_t rw;
    rw = '{w, x, k, r, u, b, rst_first, busy_start, 16'h0000};
    rows.push_back(rw);
  endtask

  // Mixed ranges, so that not every random row saturates
  task automatic random_word(output logic [15:0] v);
    integer rnd;
    rnd = $random(seed);
    v = $signed(rnd[15:0]) >>> rnd[17:16];
  endtask

  task automatic build_table();
    logic [15:0] brk [12];
    logic [15:0] w, x, k, r, u, b;
    integer      rnd;
    brk = '{16'h1000, 16'h0FFF, 16'h2600, 16'h25FF, 16'h5000, 16'h4FFF,
            16'hF000, 16'hDA00, 16'hB000, 16'h8000, 16'h7FFF, 16'h0000};
    // Small operands, then the same row again with h_prev carried
    add_row(16'h0800, 16'h1000, 16'h0400, 16'h2000, 16'h1000, 16'h0200, 1'b0, 1'b0);
    add_row(16'h0800, 16'h1000, 16'h0400, 16'h2000, 16'h1000, 16'h0200, 1'b0, 1'b0);
    // Reset first, U*h_prev must see a cleared hidden state
    add_row(16'hF800, 16'h1800, 16'h0C00, 16'hFC00, 16'h2000, 16'h0000, 1'b1, 1'b0);
    // Same operands with a stray START while busy
    add_row(16'hF800, 16'h1800, 16'h0C00, 16'hFC00, 16'h2000, 16'h0000, 1'b0, 1'b1);
    // Saturation both ways
    add_row(16'h7FFF, 16'h7FFF, 16'h7FFF, 16'h7FFF, 16'h0000, 16'h7FFF, 1'b1, 1'b0);
    add_row(16'h7FFF, 16'h8000, 16'h8000, 16'h7FFF, 16'h0000, 16'h8000, 1'b0, 1'b0);
    // Bias alone reaches the logistic input
    foreach (brk[i]) begin
      add_row(16'h0, 16'h0, 16'h0, 16'h0, 16'h0, brk[i], (i == 0), 1'b0);
    end
    repeat (N_RANDOM) begin
      random_word(w);
      random_word(x);
      random_word(k);
      random_word(r);
      random_word(u);
      random_word(b);
      rnd = $random(seed);
      add_row(w, x, k, r, u, b, 1'b0, rnd[20]);
    end
  endtask

  task automatic fill_expected();
    logic [15:0] h;
    h = 16'h0000;
    foreach (rows[i]) begin
      if (rows[i].rst_first) h = 16'h0000;
      rows[i].exp_h = expected_h(rows[i], h);
      h = rows[i].exp_h;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_fixed(input string name, input ntm_pkg::fixed_t got,
                             input ntm_pkg::fixed_t want, input int row);
    if (got !== want) begin
      mismatches++;
      $display("MISMATCH %s row %0d: got %h expected %h", name, row, got.s, want.s);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want,
                           input int row);
    if (got !== want) begin
      mismatches++;
      $display("MISMATCH %s row %0d: got %h expected %h", name, row, got, want);
    end
  endtask

  task automatic check_count(input string name, input int got, input int want,
                             input int row);
    if (got != want) begin
      mismatches++;
      $display("MISMATCH %s row %0d: got %0h expected %0h", name, row, got, want);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////////////////////////

  task automatic check_after_reset(input int row);
    @(negedge CLK);
    check_bit("READY", ready, 1'b0, row);
    check_bit("H_OUT_ENABLE", h_out_enable, 1'b0, row);
    check_fixed("H_OUT", h_out, '0, row);
    ready_exp = 1'b0;
  endtask

  task automatic apply_reset(input int row);
    @(posedge CLK);
    RST   <= 1'b1;
    start <= 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    RST <= 1'b0;
    check_after_reset(row);
  endtask

  task automatic run_row(input int idx);
    row_t rw;
    int   waited;
    logic seen;
    rw     = rows[idx];
    waited = 0;
    seen   = 1'b0;
    @(posedge CLK);
    w_in  <= rw.w;
    x_in  <= rw.x;
    k_in  <= rw.k;
    r_in  <= rw.r;
    u_in  <= rw.u;
    b_in  <= rw.b;
    start <= 1'b1;
    // Idle, previous strobe gone
    @(negedge CLK);
    check_bit("READY", ready, ready_exp, idx);
    check_bit("H_OUT_ENABLE", h_out_enable, 1'b0, idx);
    // DUT takes START on this edge
    @(posedge CLK);
    start <= 1'b0;
    while (!seen && waited < LAT_LIMIT) begin
      @(negedge CLK);
      if (h_out_enable) begin
        seen = 1'b1;
      end else begin
        check_bit("READY", ready, 1'b0, idx);
        @(posedge CLK);
        waited++;
        // Stray START mid-run, dropped again well before DONE
        if (rw.busy_start && waited == 2) start <= 1'b1;
        if (waited == 3) start <= 1'b0;
      end
    end
    if (!seen) begin
      failures++;
      $display("ERROR row %0d: H_OUT_ENABLE never rose after START", idx);
    end else begin
      // Visible after edge n+5, sampled at edge n+6
      check_count("H_OUT_ENABLE latency", waited + 1, RESULT_LATENCY, idx);
      check_bit("READY", ready, 1'b1, idx);
      check_fixed("H_OUT", h_out, rw.exp_h, idx);
      ready_exp = 1'b1;
    end
  endtask

  task automatic report_counts();
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed       = 32'hd7a4_ddac;
    mismatches = 0;
    failures   = 0;
    ready_exp  = 1'b0;
    RST        = 1'b1;
    start      = 1'b0;
    w_in       = '0;
    x_in       = '0;
    k_in       = '0;
    r_in       = '0;
    u_in       = '0;
    b_in       = '0;
    build_table();
    fill_expected();
    repeat (RESET_CYCLES) @(posedge CLK);
    RST <= 1'b0;
    check_after_reset(-1);
    foreach (rows[i]) begin
      if (rows[i].rst_first) apply_reset(i);
      run_row(i);
    end
    @(posedge CLK);
    // Failed concurrent assertions count as failures
    failures = failures + dut0.u_asserts.fail_count;
    report_counts();
    if (mismatches + failures == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    report_counts();
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
ntm_pkg.sv
ntm_fixed_mac.sv
ntm_logistic.sv
ntm_sequencer.sv
ntm_neuron_top.sv
ntm_neuron_asserts.sv
ntm_neuron_tb.sv

/* Makefile */
# Verilator build and run of the NTM controller neuron testbench

VERILATOR ?= verilator
TOP       ?= ntm_neuron_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= *** FAILED ***
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -qF '$(PASS_MSG)' $(LOG); then \
	  echo "Simulation ended without a verdict, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
